//--- Makefile
# Verilator lint and simulation of the host bridge testbench
TOP := tb_n64_host_bridge

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -qF ">>> FAIL" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@echo "Simulation finished without failure"

clean:
	rm -rf obj_dir sim.log

//--- design/aspect_ratio_table.sv
// Registered aspect ratio lookup by TV standard, vertical crop and blanking mode
`timescale 1ns/1ps
`default_nettype none

module aspect_ratio_table (
	input  logic        clk_1x,
	input  logic        RESET,
	input  logic        is_pal,
	input  logic [1:0]  crop,
	input  logic        fixed_blanks_off,
	input  logic [1:0]  ar_mode,
	output logic [12:0] video_arx,
	output logic [12:0] video_ary
);

	n64_host_pkg::aspect_t core_q;
	n64_host_pkg::aspect_t core_next;

	always_comb begin
		core_next = core_q;
		if (fixed_blanks_off) begin
			core_next = n64_host_pkg::AR_DEFAULT;
		end else begin
			case (crop)
				2'd0: core_next = is_pal ? n64_host_pkg::AR_PAL_CROP0 : n64_host_pkg::AR_NTSC_CROP0;
				2'd1: core_next = is_pal ? n64_host_pkg::AR_PAL_CROP1 : n64_host_pkg::AR_NTSC_CROP1;
				2'd2: core_next = is_pal ? n64_host_pkg::AR_PAL_CROP2 : n64_host_pkg::AR_NTSC_CROP2;
				// Crop 3 is not a menu choice, keep the last ratio
				default: core_next = core_q;
			endcase
		end
	end

	always_ff @(posedge clk_1x) begin
		if (RESET) begin
			core_q    <= n64_host_pkg::AR_DEFAULT;
			video_arx <= {1'b0, n64_host_pkg::AR_DEFAULT.x};
			video_ary <= {1'b0, n64_host_pkg::AR_DEFAULT.y};
		end else begin
			core_q <= core_next;
			if (ar_mode == 2'd0) begin
				video_arx <= {1'b0, core_next.x};
				video_ary <= {1'b0, core_next.y};
			end else begin
				// User ratio codes pass through to the scaler
				video_arx <= {11'd0, ar_mode - 2'd1};
				video_ary <= 13'd0;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/cart_ram_writer.sv
// Handheld cartridge writer: 32-bit RAM requests with host wait until accepted
`timescale 1ns/1ps
`default_nettype none

module cart_ram_writer #(
	parameter logic [26:0] GB_CART_BASE = 27'd8388608
) (
	input  logic                     clk_1x,
	input  logic                     RESET,
	input  n64_host_pkg::ioctl_bus_t ioctl,
	input  n64_host_pkg::dl_kind_t   dl_kind,
	input  logic                     mem_ready,
	output n64_host_pkg::mem_write_t mem,
	output logic                     ioctl_wait
);

	logic        beat;
	logic        req_q;
	logic [26:0] addr_q;
	logic [31:0] data_q;

	assign beat = ioctl.wr && (dl_kind == n64_host_pkg::DL_GB_CART);

	// Request from the upper halfword until the memory takes it
	always_ff @(posedge clk_1x) begin
		if (RESET) begin
			req_q <= 1'b0;
		end else if (beat && ioctl.addr[1]) begin
			req_q <= 1'b1;
		end else if (mem_ready) begin
			req_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (beat) begin
			if (!ioctl.addr[1]) begin
				data_q[15:0] <= ioctl.dout;
				addr_q       <= ioctl.addr + GB_CART_BASE;
			end else begin
				data_q[31:16] <= ioctl.dout;
			end
		end
	end

	assign mem        = '{req: req_q, addr: addr_q, data: data_q};
	// Host stalls for as long as the request is pending
	assign ioctl_wait = req_q;

	a_req_stable: assert property (
		@(posedge clk_1x) disable iff (RESET)
		(mem.req && !mem_ready) |=> ($stable(mem.addr) && $stable(mem.data))
	);

	// Wait and request drop together the cycle after acceptance
	a_release: assert property (
		@(posedge clk_1x) disable iff (RESET)
		(mem.req && mem_ready && !beat) |=> (!mem.req && !ioctl_wait)
	);

endmodule

`default_nettype wire

//--- design/download_control.sv
// Download index decoder with main cartridge loaded flag and ROM copy request
`timescale 1ns/1ps
`default_nettype none

module download_control (
	input  logic                     clk_1x,
	input  logic                     RESET,
	input  n64_host_pkg::ioctl_bus_t ioctl,
	output n64_host_pkg::dl_kind_t   dl_kind,
	output logic                     romcopy_start,
	output logic [26:0]              romcopy_size,
	output logic                     cart_loaded
);

	n64_host_pkg::dl_kind_t kind_next;
	logic                   n64_dl_end;

	// Decode the running download from the low index bits
	always_comb begin
		kind_next = n64_host_pkg::DL_NONE;
		if (ioctl.download) begin
			case (ioctl.index[5:0])
				n64_host_pkg::IDX_PIFROM:   kind_next = n64_host_pkg::DL_PIFROM;
				n64_host_pkg::IDX_N64_CART: kind_next = n64_host_pkg::DL_N64_CART;
				n64_host_pkg::IDX_GB_CART:  kind_next = n64_host_pkg::DL_GB_CART;
				default:                    kind_next = n64_host_pkg::DL_NONE;
			endcase
		end
	end

	// dl_kind still shows the previous cycle here, so this is the falling edge
	// of a main cartridge download
	assign n64_dl_end = !ioctl.download && (dl_kind == n64_host_pkg::DL_N64_CART);

	always_ff @(posedge clk_1x) begin
		if (RESET) begin
			dl_kind       <= n64_host_pkg::DL_NONE;
			romcopy_start <= 1'b0;
			cart_loaded   <= 1'b0;
		end else begin
			dl_kind       <= kind_next;
			romcopy_start <= n64_dl_end;
			// Sticky until reset
			if (dl_kind == n64_host_pkg::DL_N64_CART) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	// Size is the byte count the host reached when it dropped download
	always_ff @(posedge clk_1x) begin
		if (n64_dl_end) begin
			romcopy_size <= ioctl.addr;
		end
	end

	// One copy request per finished download
	a_romcopy_single: assert property (
		@(posedge clk_1x) disable iff (RESET)
		romcopy_start |=> !romcopy_start
	);

endmodule

`default_nettype wire

//--- design/llapi_pad_mapper.sv
// Adapter port remap into the console pad layout, with presence and menu combo detection
`timescale 1ns/1ps
`default_nettype none

module llapi_pad_mapper (
	input  logic                      clk_1x,
	input  logic                      RESET,
	input  n64_host_pkg::llapi_port_t port,
	output n64_host_pkg::pad_state_t  pad,
	output logic                      present,
	output logic                      osd_combo
);

	logic pressed;
	logic type_valid;

	// Type 0 also covers adapters that report nothing useful,
	// so the first button press counts as proof of a pad
	always_ff @(posedge clk_1x) begin
		if (RESET) begin
			pressed <= 1'b0;
		end else if (|port.buttons) begin
			pressed <= 1'b1;
		end
	end

	assign type_valid = (port.type_code != n64_host_pkg::LLAPI_TYPE_NONE) &&
		(port.type_code != n64_host_pkg::LLAPI_TYPE_INVALID);

	assign present = port.en && (type_valid || pressed);

	// ============================================================
	// Button and stick remap
	// ============================================================
	always_comb begin
		pad.buttons.b          = port.buttons[0];
		pad.buttons.a          = port.buttons[1];
		pad.buttons.c_left     = port.buttons[2];
		pad.buttons.c_down     = port.buttons[3];
		pad.buttons.z          = port.buttons[4];
		pad.buttons.start      = port.buttons[5];
		pad.buttons.l          = port.buttons[6];
		pad.buttons.r          = port.buttons[7];
		pad.buttons.c_up       = port.buttons[8];
		pad.buttons.c_right    = port.buttons[9];
		pad.buttons.dpad_right = port.buttons[24];
		pad.buttons.dpad_left  = port.buttons[25];
		pad.buttons.dpad_down  = port.buttons[26];
		pad.buttons.dpad_up    = port.buttons[27];

		// Unsigned 0..255 around 128 becomes signed around 0
		pad.stick_x = $signed(port.analog_x - n64_host_pkg::STICK_CENTRE);
		pad.stick_y = $signed(port.analog_y - n64_host_pkg::STICK_CENTRE);
	end

	// Down + start + first face button opens the menu
	assign osd_combo = port.buttons[26] & port.buttons[5] & port.buttons[0];

endmodule

`default_nettype wire

//--- design/n64_host_bridge.sv
// Top level of the host bridge: download control, packers, pad mapping and aspect table
`timescale 1ns/1ps
`default_nettype none

module n64_host_bridge #(
	parameter logic [26:0] GB_CART_BASE = 27'd8388608
) (
	input  logic                           clk_1x,
	input  logic                           RESET,
	input  n64_host_pkg::ioctl_bus_t       ioctl,
	input  logic                           mem_ready,
	input  n64_host_pkg::llapi_port_t      llapi_a,
	input  n64_host_pkg::llapi_port_t      llapi_b,
	input  n64_host_pkg::pad_state_t [3:0] usb_pads,
	input  logic                           is_pal,
	input  logic [1:0]                     crop,
	input  logic                           fixed_blanks_off,
	input  logic [1:0]                     ar_mode,
	output logic                           ioctl_wait,
	output n64_host_pkg::pifrom_write_t    pifrom,
	output n64_host_pkg::mem_write_t       mem,
	output logic                           romcopy_start,
	output logic [26:0]                    romcopy_size,
	output logic                           cart_loaded,
	output n64_host_pkg::pad_state_t [3:0] players,
	output logic                           osd_request,
	output logic [12:0]                    video_arx,
	output logic [12:0]                    video_ary
);

	n64_host_pkg::dl_kind_t   dl_kind;
	n64_host_pkg::pad_state_t pad_a;
	n64_host_pkg::pad_state_t pad_b;
	logic                     present_a;
	logic                     present_b;
	logic                     osd_a;
	logic                     osd_b;

	// ============================================================
	// Download path
	// ============================================================
	download_control i_download_control (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.ioctl         (ioctl),
		.dl_kind       (dl_kind),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.cart_loaded   (cart_loaded)
	);

	pifrom_packer i_pifrom_packer (
		.clk_1x  (clk_1x),
		.RESET   (RESET),
		.ioctl   (ioctl),
		.dl_kind (dl_kind),
		.pifrom  (pifrom)
	);

	cart_ram_writer #(
		.GB_CART_BASE (GB_CART_BASE)
	) i_cart_ram_writer (
		.clk_1x     (clk_1x),
		.RESET      (RESET),
		.ioctl      (ioctl),
		.dl_kind    (dl_kind),
		.mem_ready  (mem_ready),
		.mem        (mem),
		.ioctl_wait (ioctl_wait)
	);

	// ============================================================
	// Pad path
	// ============================================================
	llapi_pad_mapper i_llapi_pad_mapper_a (
		.clk_1x    (clk_1x),
		.RESET     (RESET),
		.port      (llapi_a),
		.pad       (pad_a),
		.present   (present_a),
		.osd_combo (osd_a)
	);

	llapi_pad_mapper i_llapi_pad_mapper_b (
		.clk_1x    (clk_1x),
		.RESET     (RESET),
		.port      (llapi_b),
		.pad       (pad_b),
		.present   (present_b),
		.osd_combo (osd_b)
	);

	player_slot_router i_player_slot_router (
		.pad_a       (pad_a),
		.pad_b       (pad_b),
		.present_a   (present_a),
		.present_b   (present_b),
		.osd_a       (osd_a),
		.osd_b       (osd_b),
		.usb_pads    (usb_pads),
		.players     (players),
		.osd_request (osd_request)
	);

	// Video aspect for the scaler
	aspect_ratio_table i_aspect_ratio_table (
		.clk_1x           (clk_1x),
		.RESET            (RESET),
		.is_pal           (is_pal),
		.crop             (crop),
		.fixed_blanks_off (fixed_blanks_off),
		.ar_mode          (ar_mode),
		.video_arx        (video_arx),
		.video_ary        (video_ary)
	);

endmodule

`default_nettype wire

//--- design/n64_host_pkg.sv
// Shared types and constants for the host bridge: buses, pads, download kinds, aspect ratios
`default_nettype none

package n64_host_pkg;

	// ============================================================
	// Host download bus and decoded download kinds
	// ============================================================
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [26:0] addr;
		logic [15:0] dout;
		logic        wr;
	} ioctl_bus_t;

	// File index codes, compared against the low six index bits
	localparam logic [5:0] IDX_PIFROM   = 6'd0;
	localparam logic [5:0] IDX_N64_CART = 6'd1;
	localparam logic [5:0] IDX_GB_CART  = 6'd2;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_PIFROM,
		DL_N64_CART,
		DL_GB_CART
	} dl_kind_t;

	// Boot ROM write port
	typedef struct packed {
		logic        wren;
		logic [9:0]  address;
		logic [31:0] data;
	} pifrom_write_t;

	// Cartridge RAM write request
	typedef struct packed {
		logic        req;
		logic [26:0] addr;
		logic [31:0] data;
	} mem_write_t;

	// ============================================================
	// Controller types
	// ============================================================
	typedef struct packed {
		logic c_left;
		logic c_down;
		logic c_right;
		logic c_up;
		logic z;
		logic r;
		logic l;
		logic start;
		logic b;
		logic a;
		logic dpad_up;
		logic dpad_down;
		logic dpad_left;
		logic dpad_right;
	} pad_buttons_t;

	typedef struct packed {
		pad_buttons_t      buttons;
		logic signed [7:0] stick_y;
		logic signed [7:0] stick_x;
	} pad_state_t;

	// Raw adapter report; type_code is the adapter's controller type
	typedef struct packed {
		logic        en;
		logic [7:0]  type_code;
		logic [31:0] buttons;
		logic [7:0]  analog_y;
		logic [7:0]  analog_x;
		logic [7:0]  analog_extra;
	} llapi_port_t;

	localparam logic [7:0] LLAPI_TYPE_NONE    = 8'd0;
	localparam logic [7:0] LLAPI_TYPE_INVALID = 8'd255;
	localparam logic [7:0] STICK_CENTRE       = 8'd128;

	// ============================================================
	// Aspect ratios
	// ============================================================
	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
	} aspect_t;

	localparam aspect_t AR_DEFAULT    = '{x: 12'd4,    y: 12'd3};
	localparam aspect_t AR_NTSC_CROP0 = '{x: 12'd512,  y: 12'd381};
	localparam aspect_t AR_NTSC_CROP1 = '{x: 12'd1280, y: 12'd889};
	localparam aspect_t AR_NTSC_CROP2 = '{x: 12'd2560, y: 12'd1714};
	localparam aspect_t AR_PAL_CROP0  = '{x: 12'd512,  y: 12'd387};
	localparam aspect_t AR_PAL_CROP1  = '{x: 12'd1024, y: 12'd731};
	localparam aspect_t AR_PAL_CROP2  = '{x: 12'd2048, y: 12'd1419};

endpackage

`default_nettype wire

//--- design/pifrom_packer.sv
// Boot ROM packer: byte-swapped halfword pairs into 32-bit PIF ROM writes
`timescale 1ns/1ps
`default_nettype none

module pifrom_packer (
	input  logic                        clk_1x,
	input  logic                        RESET,
	input  n64_host_pkg::ioctl_bus_t    ioctl,
	input  n64_host_pkg::dl_kind_t      dl_kind,
	output n64_host_pkg::pifrom_write_t pifrom
);

	logic        beat;
	logic        wren_q;
	logic [9:0]  address_q;
	logic [31:0] data_q;

	assign beat = ioctl.wr && (dl_kind == n64_host_pkg::DL_PIFROM);

	// Strobe after the upper halfword of each pair
	always_ff @(posedge clk_1x) begin
		if (RESET) begin
			wren_q <= 1'b0;
		end else begin
			wren_q <= beat && ioctl.addr[1];
		end
	end

	// Host halfwords arrive little endian, the ROM wants big endian words
	always_ff @(posedge clk_1x) begin
		if (beat) begin
			if (!ioctl.addr[1]) begin
				data_q[31:24] <= ioctl.dout[7:0];
				data_q[23:16] <= ioctl.dout[15:8];
				// Index bit 6 selects the upper ROM half
				address_q     <= {ioctl.index[6], ioctl.addr[10:2]};
			end else begin
				data_q[15:8]  <= ioctl.dout[7:0];
				data_q[7:0]   <= ioctl.dout[15:8];
			end
		end
	end

	assign pifrom = '{wren: wren_q, address: address_q, data: data_q};

endmodule

`default_nettype wire

//--- design/player_slot_router.sv
// Player slot router: adapters take the lowest slots, USB pads fill the rest
`timescale 1ns/1ps
`default_nettype none

module player_slot_router (
	input  n64_host_pkg::pad_state_t       pad_a,
	input  n64_host_pkg::pad_state_t       pad_b,
	input  logic                           present_a,
	input  logic                           present_b,
	input  logic                           osd_a,
	input  logic                           osd_b,
	input  n64_host_pkg::pad_state_t [3:0] usb_pads,
	output n64_host_pkg::pad_state_t [3:0] players,
	output logic                           osd_request
);

	always_comb begin
		case ({present_a, present_b})
			2'b11: begin
				players[0] = pad_a;
				players[1] = pad_b;
				players[2] = usb_pads[0];
				players[3] = usb_pads[1];
			end
			2'b10: begin
				players[0] = pad_a;
				players[1] = usb_pads[0];
				players[2] = usb_pads[1];
				players[3] = usb_pads[2];
			end
			2'b01: begin
				// Port B keeps slot 1 even when A is absent
				players[0] = usb_pads[0];
				players[1] = pad_b;
				players[2] = usb_pads[1];
				players[3] = usb_pads[2];
			end
			default: begin
				players = usb_pads;
			end
		endcase
	end

	// Either adapter's menu combo
	assign osd_request = osd_a | osd_b;

endmodule

`default_nettype wire

//--- filelist.f
design/n64_host_pkg.sv
design/download_control.sv
design/pifrom_packer.sv
design/cart_ram_writer.sv
design/llapi_pad_mapper.sv
design/player_slot_router.sv
design/aspect_ratio_table.sv
design/n64_host_bridge.sv
verification/tb_n64_host_bridge.sv

//--- verification/tb_n64_host_bridge.sv
// Testbench for the host bridge: clock, reset, directed download, pad and aspect tests
`timescale 1ns/1ps
`default_nettype none

module tb_n64_host_bridge;

	localparam logic [26:0] GB_BASE    = 27'h0400000;
	localparam int          WAIT_LIMIT = 50;

	logic                           clk_1x = 1'b0;
	logic                           RESET;
	n64_host_pkg::ioctl_bus_t       ioctl;
	logic                           mem_ready;
	n64_host_pkg::llapi_port_t      llapi_a;
	n64_host_pkg::llapi_port_t      llapi_b;
	n64_host_pkg::pad_state_t [3:0] usb_pads;
	logic                           is_pal;
	logic [1:0]                     crop;
	logic                           fixed_blanks_off;
	logic [1:0]                     ar_mode;
	logic                           ioctl_wait;
	n64_host_pkg::pifrom_write_t    pifrom;
	n64_host_pkg::mem_write_t       mem;
	logic                           romcopy_start;
	logic [26:0]                    romcopy_size;
	logic                           cart_loaded;
	n64_host_pkg::pad_state_t [3:0] players;
	logic                           osd_request;
	logic [12:0]                    video_arx;
	logic [12:0]                    video_ary;

	logic [31:0] rng = 32'd69315;
	int          value_errors = 0;
	int          timeout_errors = 0;

	n64_host_bridge #(
		.GB_CART_BASE (GB_BASE)
	) i_n64_host_bridge (
		.clk_1x           (clk_1x),
		.RESET            (RESET),
		.ioctl            (ioctl),
		.mem_ready        (mem_ready),
		.llapi_a          (llapi_a),
		.llapi_b          (llapi_b),
		.usb_pads         (usb_pads),
		.is_pal           (is_pal),
		.crop             (crop),
		.fixed_blanks_off (fixed_blanks_off),
		.ar_mode          (ar_mode),
		.ioctl_wait       (ioctl_wait),
		.pifrom           (pifrom),
		.mem              (mem),
		.romcopy_start    (romcopy_start),
		.romcopy_size     (romcopy_size),
		.cart_loaded      (cart_loaded),
		.players          (players),
		.osd_request      (osd_request),
		.video_arx        (video_arx),
		.video_ary        (video_ary)
	);

	// 40 ns period
	always #20 clk_1x = ~clk_1x;

	// ============================================================
	// Reference models and stimulus helpers
	// ============================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic n64_host_pkg::llapi_port_t make_port(input logic en,
			input logic [7:0] kind, input logic [31:0] buttons, input logic [15:0] analog);
		n64_host_pkg::llapi_port_t p;
		p.en           = en;
		p.type_code    = kind;
		p.buttons      = buttons;
		p.analog_y     = analog[15:8];
		p.analog_x     = analog[7:0];
		p.analog_extra = 8'd0;
		return p;
	endfunction

	// Adapter button numbers to console pad fields, sticks centred on 128
	function automatic n64_host_pkg::pad_state_t map_port(input n64_host_pkg::llapi_port_t p);
		n64_host_pkg::pad_state_t m;
		m.buttons.b          = p.buttons[0];
		m.buttons.a          = p.buttons[1];
		m.buttons.c_left     = p.buttons[2];
		m.buttons.c_down     = p.buttons[3];
		m.buttons.z          = p.buttons[4];
		m.buttons.start      = p.buttons[5];
		m.buttons.l          = p.buttons[6];
		m.buttons.r          = p.buttons[7];
		m.buttons.c_up       = p.buttons[8];
		m.buttons.c_right    = p.buttons[9];
		m.buttons.dpad_right = p.buttons[24];
		m.buttons.dpad_left  = p.buttons[25];
		m.buttons.dpad_down  = p.buttons[26];
		m.buttons.dpad_up    = p.buttons[27];
		m.stick_x            = p.analog_x - 8'd128;
		m.stick_y            = p.analog_y - 8'd128;
		return m;
	endfunction

	function automatic n64_host_pkg::aspect_t core_ratio(input logic pal,
			input logic [1:0] crop_sel);
		n64_host_pkg::aspect_t r;
		case ({pal, crop_sel})
			3'b000:  r = '{x: 12'd512,  y: 12'd381};
			3'b001:  r = '{x: 12'd1280, y: 12'd889};
			3'b010:  r = '{x: 12'd2560, y: 12'd1714};
			3'b100:  r = '{x: 12'd512,  y: 12'd387};
			3'b101:  r = '{x: 12'd1024, y: 12'd731};
			3'b110:  r = '{x: 12'd2048, y: 12'd1419};
			default: r = '{x: 12'd4,    y: 12'd3};
		endcase
		return r;
	endfunction

	task automatic apply_reset();
		@(posedge clk_1x);
		RESET <= 1'b1;
		repeat (4) @(posedge clk_1x);
		RESET <= 1'b0;
	endtask

	task automatic start_download(input logic [7:0] idx);
		@(posedge clk_1x);
		ioctl.download <= 1'b1;
		ioctl.index    <= idx;
		ioctl.wr       <= 1'b0;
		ioctl.addr     <= 27'd0;
		// Let the decoded kind settle
		@(posedge clk_1x);
	endtask

	task automatic drive_beat(input logic [7:0] idx, input logic [26:0] addr,
			input logic [15:0] dout);
		@(posedge clk_1x);
		ioctl.index <= idx;
		ioctl.addr  <= addr;
		ioctl.dout  <= dout;
		ioctl.wr    <= 1'b1;
	endtask

	task automatic drive_idle();
		@(posedge clk_1x);
		ioctl.wr <= 1'b0;
	endtask

	task automatic drive_ports(input n64_host_pkg::llapi_port_t a,
			input n64_host_pkg::llapi_port_t b);
		@(posedge clk_1x);
		llapi_a <= a;
		llapi_b <= b;
		@(negedge clk_1x);
	endtask

	task automatic drive_aspect(input logic pal, input logic [1:0] crop_sel, input logic fbo,
			input logic [1:0] mode);
		@(posedge clk_1x);
		is_pal           <= pal;
		crop             <= crop_sel;
		fixed_blanks_off <= fbo;
		ar_mode          <= mode;
		// Table registers one cycle later
		@(posedge clk_1x);
		@(negedge clk_1x);
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: no %s within %0d cycles", what, WAIT_LIMIT);
		timeout_errors++;
	endtask

	// ============================================================
	// Compare tasks
	// ============================================================
	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_size(input string name, input logic [26:0] exp, input logic [26:0] act);
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_pifrom(input string name, input n64_host_pkg::pifrom_write_t exp,
			input n64_host_pkg::pifrom_write_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_mem(input string name, input n64_host_pkg::mem_write_t exp,
			input n64_host_pkg::mem_write_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_pad(input string name, input n64_host_pkg::pad_state_t exp,
			input n64_host_pkg::pad_state_t act);
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_aspect(input string name, input n64_host_pkg::aspect_t exp,
			input logic [12:0] act_x, input logic [12:0] act_y);
		if (({1'b0, exp.x} !== act_x) || ({1'b0, exp.y} !== act_y)) begin
			$display("FAIL %s: expected %0d:%0d, actual %0d:%0d", name, exp.x, exp.y,
				act_x, act_y);
			value_errors++;
		end
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic reset_state();
		n64_host_pkg::aspect_t four_three;
		four_three = '{x: 12'd4, y: 12'd3};
		@(negedge clk_1x);
		check_bit("reset_wren", 1'b0, pifrom.wren);
		check_bit("reset_req", 1'b0, mem.req);
		check_bit("reset_wait", 1'b0, ioctl_wait);
		check_bit("reset_romcopy_start", 1'b0, romcopy_start);
		check_bit("reset_cart_loaded", 1'b0, cart_loaded);
		check_aspect("reset_aspect", four_three, video_arx, video_ary);
	endtask

	task automatic pifrom_download();
		n64_host_pkg::pifrom_write_t expected;
		logic [26:0] addr;
		logic [15:0] lo;
		logic [15:0] hi;
		logic [7:0]  idx;
		int          k;
		int          cycles;
		start_download(8'h00);
		for (k = 0; k < 6; k++) begin
			rng  = xorshift32(rng);
			lo   = rng[15:0];
			hi   = rng[31:16];
			rng  = xorshift32(rng);
			addr = {16'd0, rng[8:0], 2'b00};
			// Index bit 6 picks the ROM half while the low bits still decode as PIF ROM
			idx  = {1'b0, rng[9], 6'd0};
			drive_beat(idx, addr, lo);
			drive_beat(idx, addr | 27'd2, hi);
			drive_idle();
			cycles = 0;
			@(negedge clk_1x);
			while (!pifrom.wren && cycles < WAIT_LIMIT) begin
				@(negedge clk_1x);
				cycles++;
			end
			if (!pifrom.wren) begin
				report_timeout("PIF ROM write strobe");
			end
			expected.wren    = 1'b1;
			expected.address = {idx[6], addr[10:2]};
			expected.data    = {lo[7:0], lo[15:8], hi[7:0], hi[15:8]};
			check_pifrom("pifrom_write", expected, pifrom);
			check_bit("pifrom_no_mem_req", 1'b0, mem.req);
			@(negedge clk_1x);
			check_bit("pifrom_wren_single", 1'b0, pifrom.wren);
		end
		@(posedge clk_1x);
		ioctl.download <= 1'b0;
	endtask

	task automatic gb_cart_download();
		n64_host_pkg::mem_write_t expected;
		logic [26:0] addr;
		logic [15:0] lo;
		logic [15:0] hi;
		int          k;
		int          i;
		int          delay;
		int          cycles;
		start_download(8'h02);
		addr = 27'd0;
		for (k = 0; k < 6; k++) begin
			rng   = xorshift32(rng);
			lo    = rng[15:0];
			hi    = rng[31:16];
			rng   = xorshift32(rng);
			delay = int'(rng[2:0]);
			drive_beat(8'h02, addr, lo);
			drive_beat(8'h02, addr | 27'd2, hi);
			drive_idle();
			cycles = 0;
			@(negedge clk_1x);
			while (!mem.req && cycles < WAIT_LIMIT) begin
				@(negedge clk_1x);
				cycles++;
			end
			if (!mem.req) begin
				report_timeout("cartridge RAM request");
			end
			expected.req  = 1'b1;
			expected.addr = addr + GB_BASE;
			expected.data = {hi, lo};
			check_mem("gb_cart_request", expected, mem);
			check_bit("gb_cart_wait_high", 1'b1, ioctl_wait);
			// Request holds still while the memory withholds ready
			for (i = 0; i < delay; i++) begin
				@(negedge clk_1x);
				check_mem("gb_cart_held", expected, mem);
				check_bit("gb_cart_wait_held", 1'b1, ioctl_wait);
			end
			@(posedge clk_1x);
			mem_ready <= 1'b1;
			@(posedge clk_1x);
			mem_ready <= 1'b0;
			cycles = 0;
			@(negedge clk_1x);
			while (ioctl_wait && cycles < WAIT_LIMIT) begin
				@(negedge clk_1x);
				cycles++;
			end
			if (ioctl_wait) begin
				report_timeout("release of host wait");
			end
			check_bit("gb_cart_req_released", 1'b0, mem.req);
			addr = addr + 27'd4;
		end
		@(posedge clk_1x);
		ioctl.download <= 1'b0;
		@(negedge clk_1x);
		check_bit("gb_cart_no_loaded_flag", 1'b0, cart_loaded);
	endtask

	task automatic n64_cart_download();
		logic [26:0] addr;
		logic [26:0] last_addr;
		int          k;
		int          cycles;
		check_bit("n64_cart_loaded_before", 1'b0, cart_loaded);
		start_download(8'h01);
		cycles = 0;
		@(negedge clk_1x);
		while (!cart_loaded && cycles < WAIT_LIMIT) begin
			@(negedge clk_1x);
			cycles++;
		end
		if (!cart_loaded) begin
			report_timeout("cart loaded flag");
		end
		addr      = 27'h0100000;
		last_addr = addr;
		for (k = 0; k < 4; k++) begin
			rng = xorshift32(rng);
			drive_beat(8'h01, addr, rng[15:0]);
			last_addr = addr;
			addr      = addr + 27'd2;
		end
		@(posedge clk_1x);
		ioctl.wr       <= 1'b0;
		ioctl.download <= 1'b0;
		cycles = 0;
		@(negedge clk_1x);
		while (!romcopy_start && cycles < WAIT_LIMIT) begin
			@(negedge clk_1x);
			cycles++;
		end
		if (!romcopy_start) begin
			report_timeout("ROM copy request");
		end
		check_size("n64_cart_romcopy_size", last_addr, romcopy_size);
		for (k = 0; k < 4; k++) begin
			@(negedge clk_1x);
			check_bit("n64_cart_romcopy_single", 1'b0, romcopy_start);
			check_bit("n64_cart_loaded_sticky", 1'b1, cart_loaded);
		end
	endtask

	task automatic slot_routing();
		n64_host_pkg::llapi_port_t port_a;
		n64_host_pkg::llapi_port_t port_b;
		n64_host_pkg::pad_state_t  usb [4];
		n64_host_pkg::pad_state_t  expected [4];
		logic [31:0]               btn;
		int                        c;
		int                        i;
		// Case bit 1 enables adapter A and bit 0 enables adapter B
		for (c = 0; c < 4; c++) begin
			rng    = xorshift32(rng);
			btn    = rng;
			rng    = xorshift32(rng);
			port_a = make_port(c[1], 8'd5, btn, rng[15:0]);
			port_b = make_port(c[0], 8'd9, ~btn, rng[31:16]);
			for (i = 0; i < 4; i++) begin
				rng    = xorshift32(rng);
				usb[i] = rng[29:0];
			end
			case (c)
				3:       expected = '{map_port(port_a), map_port(port_b), usb[0], usb[1]};
				2:       expected = '{map_port(port_a), usb[0], usb[1], usb[2]};
				1:       expected = '{usb[0], map_port(port_b), usb[1], usb[2]};
				default: expected = usb;
			endcase
			@(posedge clk_1x);
			llapi_a <= port_a;
			llapi_b <= port_b;
			for (i = 0; i < 4; i++) begin
				usb_pads[i] <= usb[i];
			end
			@(negedge clk_1x);
			for (i = 0; i < 4; i++) begin
				check_pad($sformatf("slot_routing_case%0d_slot%0d", c, i), expected[i],
					players[i]);
			end
		end
	endtask

	task automatic type_zero_presence();
		n64_host_pkg::llapi_port_t port_a;
		n64_host_pkg::llapi_port_t port_b;
		port_a = make_port(1'b1, 8'd0, 32'd0, 16'h8080);
		port_b = make_port(1'b0, 8'd9, 32'd0, 16'h8080);
		drive_ports(port_a, port_b);
		check_pad("type_zero_idle_absent", usb_pads[0], players[0]);
		port_a.buttons = 32'h0000_0002;
		drive_ports(port_a, port_b);
		check_pad("type_zero_press_pending", usb_pads[0], players[0]);
		@(negedge clk_1x);
		check_pad("type_zero_now_present", map_port(port_a), players[0]);
		check_pad("type_zero_usb_slot1", usb_pads[0], players[1]);
		port_a.buttons = 32'd0;
		drive_ports(port_a, port_b);
		check_pad("type_zero_sticky_centred", map_port(port_a), players[0]);

		// Menu combo is d-pad down, start and B
		port_a.buttons = 32'h0400_0021;
		drive_ports(port_a, port_b);
		check_bit("osd_combo_port_a", 1'b1, osd_request);
		port_a.buttons = 32'h0400_0020;
		drive_ports(port_a, port_b);
		check_bit("osd_partial_combo", 1'b0, osd_request);
		port_a.buttons = 32'd0;
		port_b = make_port(1'b1, 8'd9, 32'h0400_0021, 16'h8080);
		drive_ports(port_a, port_b);
		check_bit("osd_combo_port_b", 1'b1, osd_request);
		port_b.buttons = 32'd0;
		drive_ports(port_a, port_b);
		check_bit("osd_combo_released", 1'b0, osd_request);
	endtask

	task automatic aspect_ratios();
		n64_host_pkg::aspect_t expected;
		int p;
		int c;
		int m;
		for (p = 0; p < 2; p++) begin
			for (c = 0; c < 3; c++) begin
				drive_aspect(p[0], c[1:0], 1'b0, 2'd0);
				check_aspect($sformatf("aspect_pal%0d_crop%0d", p, c),
					core_ratio(p[0], c[1:0]), video_arx, video_ary);
			end
		end
		drive_aspect(1'b1, 2'd1, 1'b0, 2'd0);
		drive_aspect(1'b1, 2'd3, 1'b0, 2'd0);
		check_aspect("aspect_crop3_holds", core_ratio(1'b1, 2'd1), video_arx, video_ary);
		drive_aspect(1'b0, 2'd2, 1'b1, 2'd0);
		expected = '{x: 12'd4, y: 12'd3};
		check_aspect("aspect_blanks_off", expected, video_arx, video_ary);
		for (m = 1; m < 4; m++) begin
			drive_aspect(1'b0, 2'd0, 1'b0, m[1:0]);
			expected.x = {10'd0, m[1:0] - 2'd1};
			expected.y = 12'd0;
			check_aspect($sformatf("aspect_user_mode%0d", m), expected, video_arx, video_ary);
		end
	endtask

	initial begin
		RESET            <= 1'b1;
		ioctl            <= '0;
		mem_ready        <= 1'b0;
		llapi_a          <= '0;
		llapi_b          <= '0;
		usb_pads         <= '0;
		is_pal           <= 1'b0;
		crop             <= 2'd0;
		fixed_blanks_off <= 1'b0;
		ar_mode          <= 2'd0;

		apply_reset();
		reset_state();
		pifrom_download();
		gb_cart_download();
		n64_cart_download();
		slot_routing();
		// Idle adapters so the sticky pressed flags stay clear after reset
		@(posedge clk_1x);
		llapi_a <= '0;
		llapi_b <= '0;
		apply_reset();
		type_zero_presence();
		aspect_ratios();

		$display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
